/* ising_config.svh */
// ##############################
// ising core configuration
// sizes and widths shared by the
// spin annealing datapath
// ##############################

`ifndef ISING_CONFIG_SVH
`define ISING_CONFIG_SVH

// spin vector
`define ISING_NUM_SPIN 16

// signed weight and bias widths
`define ISING_BITJ 4
`define ISING_BITH 4

// J rows delivered per weight memory word
`define ISING_PARALLELISM 4
`define ISING_NUM_BLOCK (`ISING_NUM_SPIN / `ISING_PARALLELISM)

`define ISING_SCALING_BIT 4
`define ISING_ENERGY_BIT 32
`define ISING_FLIP_ADDR_BIT 10

// weight prefetch buffer entries
`define ISING_FETCH_DEPTH 2

`endif

/* ising_data_pkg.sv */
// ##############################
// ising data types
// spin, weight, bias, energy and
// address vectors of the core
// ##############################

`default_nettype none

`include "ising_config.svh"

package ising_data_pkg;

    typedef logic [`ISING_NUM_SPIN-1:0] spin_t;
    typedef logic signed [`ISING_ENERGY_BIT-1:0] energy_t;

    // row r of a word sits at bits [r*NUM_SPIN*BITJ +: NUM_SPIN*BITJ]
    typedef logic [`ISING_PARALLELISM*`ISING_NUM_SPIN*`ISING_BITJ-1:0] weight_word_t;

    typedef logic [`ISING_NUM_SPIN*`ISING_BITH-1:0] hbias_t;
    typedef logic [`ISING_SCALING_BIT-1:0] hscaling_t;
    typedef logic [$clog2(`ISING_NUM_BLOCK)-1:0] waddr_t;
    typedef logic [`ISING_FLIP_ADDR_BIT:0] faddr_t;

    typedef struct packed {
        spin_t   spin;
        energy_t energy;
    } spin_energy_t;

endpackage

`default_nettype wire

/* ising_ctrl_pkg.sv */
// ##############################
// ising control types
// FSM state encodings
// ##############################

`default_nettype none

package ising_ctrl_pkg;

    typedef enum logic [1:0] {
        EM_IDLE,
        EM_ACCUM,
        EM_DONE
    } em_state_e;

    typedef enum logic [1:0] {
        FM_IDLE,
        FM_EVAL,
        FM_FETCH_ICON,
        FM_WAIT
    } fm_state_e;

endpackage

`default_nettype wire

/* weight_fetch.sv */
// ##############################
// weight fetch
// prefetches J words from the
// weight memory into a stream
// ##############################

`timescale 1ns/100ps
`default_nettype none

`include "ising_config.svh"

module weight_fetch (
    input  logic                        clk_i,
    input  logic                        reset_i,
    output logic                        mem_ren_o,
    output ising_data_pkg::waddr_t      mem_raddr_o,
    input  ising_data_pkg::weight_word_t mem_rdata_i,
    output logic                        data_valid_o,
    input  logic                        data_ready_i,
    output ising_data_pkg::weight_word_t data_o
);
    localparam int DEPTH = `ISING_FETCH_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ising_data_pkg::weight_word_t buf_q [DEPTH];
    ising_data_pkg::waddr_t raddr_q;
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W:0] in_use;
    logic inflight_q;
    logic push, pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // memory answers one cycle after the read
    assign push = inflight_q;
    assign pop = data_valid_o && data_ready_i;

    // a word leaving this cycle frees its slot for a new read
    assign in_use = {1'b0, count_q} + (CNT_W+1)'(inflight_q) - (CNT_W+1)'(pop);
    assign mem_ren_o = (in_use < (CNT_W+1)'(DEPTH));
    assign mem_raddr_o = raddr_q;

    assign data_valid_o = (count_q != '0);
    assign data_o = buf_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wr_ptr_q] <= mem_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            raddr_q <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            inflight_q <= 1'b0;
        end else begin
            inflight_q <= mem_ren_o;
            if (mem_ren_o) begin
                // addresses wrap so every pass starts at block 0
                raddr_q <= (raddr_q == ising_data_pkg::waddr_t'(`ISING_NUM_BLOCK - 1)) ?
                           '0 : raddr_q + 1'b1;
            end
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    no_push_when_full: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(push && (count_q == CNT_W'(DEPTH)))
    ) else $error("weight_fetch: buffer pushed while full");

endmodule

`default_nettype wire

/* energy_monitor.sv */
// ##############################
// energy monitor
// Ising energy of one spin vector
// over a full pass of J blocks
// ##############################

`timescale 1ns/100ps
`default_nettype none

`include "ising_config.svh"

module energy_monitor (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         spin_valid_i,
    output logic                         spin_ready_o,
    input  ising_data_pkg::spin_t        spin_i,
    input  logic                         weight_valid_i,
    output logic                         weight_ready_o,
    input  ising_data_pkg::weight_word_t weight_i,
    input  ising_data_pkg::hbias_t       hbias_i,
    input  ising_data_pkg::hscaling_t    hscaling_i,
    output logic                         energy_valid_o,
    input  logic                         energy_ready_i,
    output ising_data_pkg::spin_energy_t result_o
);
    localparam int NUM_SPIN = `ISING_NUM_SPIN;
    localparam int PAR = `ISING_PARALLELISM;
    localparam int BITJ = `ISING_BITJ;
    localparam int BITH = `ISING_BITH;

    ising_ctrl_pkg::em_state_e state_q;
    ising_data_pkg::spin_t spin_q;
    ising_data_pkg::energy_t energy_q;
    ising_data_pkg::energy_t block_sum;
    ising_data_pkg::waddr_t blk_q;
    logic spin_hs, weight_hs, last_blk;

    assign spin_ready_o = (state_q == ising_ctrl_pkg::EM_IDLE);
    assign weight_ready_o = (state_q == ising_ctrl_pkg::EM_ACCUM);
    assign energy_valid_o = (state_q == ising_ctrl_pkg::EM_DONE);

    assign spin_hs = spin_valid_i && spin_ready_o;
    assign weight_hs = weight_valid_i && weight_ready_o;
    assign last_blk = (blk_q == ising_data_pkg::waddr_t'(`ISING_NUM_BLOCK - 1));

    assign result_o.spin = spin_q;
    assign result_o.energy = energy_q;

    // contribution of rows blk*PAR .. blk*PAR+PAR-1
    always_comb begin : block_energy
        ising_data_pkg::energy_t acc;
        ising_data_pkg::energy_t w;
        ising_data_pkg::energy_t h;
        ising_data_pkg::energy_t scale;
        int row;
        acc = '0;
        // scaling factor is unsigned
        scale = $signed({1'b0, hscaling_i});
        for (int r = 0; r < PAR; r++) begin
            row = int'(blk_q) * PAR + r;
            for (int j = 0; j < NUM_SPIN; j++) begin
                w = $signed(weight_i[(r * NUM_SPIN + j) * BITJ +: BITJ]);
                // equal spins give +J, opposite spins -J
                if (spin_q[row] == spin_q[j]) begin
                    acc = acc + w;
                end else begin
                    acc = acc - w;
                end
            end
            h = $signed(hbias_i[row * BITH +: BITH]);
            if (spin_q[row]) begin
                acc = acc + h * scale;
            end else begin
                acc = acc - h * scale;
            end
        end
        block_sum = acc;
    end

    always_ff @(posedge clk_i) begin
        if (spin_hs) begin
            spin_q <= spin_i;
            energy_q <= '0;
        end else if (weight_hs) begin
            energy_q <= energy_q + block_sum;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ising_ctrl_pkg::EM_IDLE;
            blk_q <= '0;
        end else begin
            case (state_q)
                ising_ctrl_pkg::EM_IDLE: begin
                    if (spin_hs) begin
                        blk_q <= '0;
                        state_q <= ising_ctrl_pkg::EM_ACCUM;
                    end
                end
                ising_ctrl_pkg::EM_ACCUM: begin
                    if (weight_hs) begin
                        blk_q <= blk_q + 1'b1;
                        if (last_blk) begin
                            state_q <= ising_ctrl_pkg::EM_DONE;
                        end
                    end
                end
                ising_ctrl_pkg::EM_DONE: begin
                    // hold result until the flip manager takes it
                    if (energy_ready_i) begin
                        state_q <= ising_ctrl_pkg::EM_IDLE;
                    end
                end
                default: state_q <= ising_ctrl_pkg::EM_IDLE;
            endcase
        end
    end

    result_held: assert property (
        @(posedge clk_i) disable iff (reset_i)
        energy_valid_o && !energy_ready_i |=> energy_valid_o && $stable(result_o)
    ) else $error("energy_monitor: result changed while stalled");

endmodule

`default_nettype wire

/* flip_manager.sv */
// ##############################
// flip manager
// keeps best spin and energy,
// issues flipped candidates
// ##############################

`timescale 1ns/100ps
`default_nettype none

module flip_manager (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         config_valid_i,
    input  ising_data_pkg::spin_t        config_spin_i,
    input  logic                         en_comparison_i,
    input  logic                         cmpt_en_i,
    output logic                         cmpt_idle_o,
    output logic                         spin_valid_o,
    input  logic                         spin_ready_i,
    output ising_data_pkg::spin_t        spin_o,
    input  logic                         energy_valid_i,
    output logic                         energy_ready_o,
    input  ising_data_pkg::spin_energy_t result_i,
    output logic                         flip_ren_o,
    output ising_data_pkg::faddr_t       flip_raddr_o,
    input  ising_data_pkg::faddr_t       icon_last_raddr_plus_one_i,
    input  ising_data_pkg::spin_t        flip_rdata_i,
    output logic                         energy_fifo_update_o,
    output ising_data_pkg::energy_t      energy_fifo_o,
    output ising_data_pkg::spin_t        spin_fifo_o
);
    ising_ctrl_pkg::fm_state_e state_q;
    ising_data_pkg::spin_t spin_q, cand_q, cand_mux;
    ising_data_pkg::energy_t energy_q;
    ising_data_pkg::faddr_t raddr_q;
    logic cmpt_en_q, cmpt_rise;
    logic first_q, icon_pending_q, update_q;
    logic energy_hs, accept;

    assign cmpt_rise = cmpt_en_i && !cmpt_en_q;

    // icon data is only valid the cycle after the read
    assign cand_mux = icon_pending_q ? (spin_q ^ flip_rdata_i) : cand_q;

    assign spin_valid_o = (state_q == ising_ctrl_pkg::FM_EVAL);
    assign spin_o = cand_mux;
    assign energy_ready_o = (state_q == ising_ctrl_pkg::FM_WAIT);
    assign energy_hs = energy_valid_i && energy_ready_o;

    // first result of a run always wins
    assign accept = first_q || !en_comparison_i || (result_i.energy < energy_q);

    assign flip_ren_o = (state_q == ising_ctrl_pkg::FM_FETCH_ICON);
    assign flip_raddr_o = raddr_q;
    assign cmpt_idle_o = (state_q == ising_ctrl_pkg::FM_IDLE);

    assign energy_fifo_update_o = update_q;
    assign energy_fifo_o = energy_q;
    assign spin_fifo_o = spin_q;

    always_ff @(posedge clk_i) begin
        if (cmpt_idle_o && config_valid_i) begin
            spin_q <= config_spin_i;
        end else if (energy_hs && accept) begin
            spin_q <= result_i.spin;
            energy_q <= result_i.energy;
        end
        if (cmpt_idle_o) begin
            cand_q <= config_valid_i ? config_spin_i : spin_q;
        end else if (spin_valid_o) begin
            cand_q <= cand_mux;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ising_ctrl_pkg::FM_IDLE;
            cmpt_en_q <= 1'b0;
            raddr_q <= '0;
            first_q <= 1'b0;
            icon_pending_q <= 1'b0;
            update_q <= 1'b0;
        end else begin
            cmpt_en_q <= cmpt_en_i;
            icon_pending_q <= flip_ren_o;
            update_q <= energy_hs && accept;
            case (state_q)
                ising_ctrl_pkg::FM_IDLE: begin
                    if (cmpt_rise) begin
                        raddr_q <= '0;
                        first_q <= 1'b1;
                        state_q <= ising_ctrl_pkg::FM_EVAL;
                    end
                end
                ising_ctrl_pkg::FM_EVAL: begin
                    if (spin_ready_i) begin
                        state_q <= ising_ctrl_pkg::FM_WAIT;
                    end
                end
                ising_ctrl_pkg::FM_WAIT: begin
                    if (energy_hs) begin
                        first_q <= 1'b0;
                        state_q <= (raddr_q == icon_last_raddr_plus_one_i) ?
                                   ising_ctrl_pkg::FM_IDLE : ising_ctrl_pkg::FM_FETCH_ICON;
                    end
                end
                ising_ctrl_pkg::FM_FETCH_ICON: begin
                    raddr_q <= raddr_q + 1'b1;
                    state_q <= ising_ctrl_pkg::FM_EVAL;
                end
                default: state_q <= ising_ctrl_pkg::FM_IDLE;
            endcase
        end
    end

    icon_addr_in_range: assert property (
        @(posedge clk_i) disable iff (reset_i)
        flip_ren_o |-> (flip_raddr_o != icon_last_raddr_plus_one_i)
    ) else $error("flip_manager: icon read past last address");

endmodule

`default_nettype wire

/* digital_macro.sv */
// ##############################
// digital macro
// weight fetch, energy monitor
// and flip manager loop
// ##############################

`timescale 1ns/100ps
`default_nettype none

module digital_macro (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         config_valid_fm_i,
    input  ising_data_pkg::spin_t        config_spin_initial_i,
    input  logic                         en_comparison_i,
    input  logic                         cmpt_en_i,
    output logic                         cmpt_idle_o,
    output logic                         flip_ren_o,
    output ising_data_pkg::faddr_t       flip_raddr_o,
    input  ising_data_pkg::faddr_t       icon_last_raddr_plus_one_i,
    input  ising_data_pkg::spin_t        flip_rdata_i,
    output logic                         dgt_weight_ren_o,
    output ising_data_pkg::waddr_t       dgt_weight_raddr_o,
    input  ising_data_pkg::weight_word_t dgt_weight_i,
    input  ising_data_pkg::hbias_t       dgt_hbias_i,
    input  ising_data_pkg::hscaling_t    dgt_hscaling_i,
    output logic                         energy_fifo_update_o,
    output ising_data_pkg::energy_t      energy_fifo_o,
    output ising_data_pkg::spin_t        spin_fifo_o
);
    logic weight_valid, weight_ready;
    logic spin_valid, spin_ready;
    logic energy_valid, energy_ready;
    ising_data_pkg::weight_word_t weight_word;
    ising_data_pkg::spin_t cand_spin;
    ising_data_pkg::spin_energy_t em_result;

    weight_fetch u_weight_fetch (
        .clk_i        (clk_i             ),
        .reset_i      (reset_i           ),
        .mem_ren_o    (dgt_weight_ren_o  ),
        .mem_raddr_o  (dgt_weight_raddr_o),
        .mem_rdata_i  (dgt_weight_i      ),
        .data_valid_o (weight_valid      ),
        .data_ready_i (weight_ready      ),
        .data_o       (weight_word       )
    );

    energy_monitor u_energy_monitor (
        .clk_i          (clk_i         ),
        .reset_i        (reset_i       ),
        .spin_valid_i   (spin_valid    ),
        .spin_ready_o   (spin_ready    ),
        .spin_i         (cand_spin     ),
        .weight_valid_i (weight_valid  ),
        .weight_ready_o (weight_ready  ),
        .weight_i       (weight_word   ),
        .hbias_i        (dgt_hbias_i   ),
        .hscaling_i     (dgt_hscaling_i),
        .energy_valid_o (energy_valid  ),
        .energy_ready_i (energy_ready  ),
        .result_o       (em_result     )
    );

    flip_manager u_flip_manager (
        .clk_i                      (clk_i                     ),
        .reset_i                    (reset_i                   ),
        .config_valid_i             (config_valid_fm_i         ),
        .config_spin_i              (config_spin_initial_i     ),
        .en_comparison_i            (en_comparison_i           ),
        .cmpt_en_i                  (cmpt_en_i                 ),
        .cmpt_idle_o                (cmpt_idle_o               ),
        .spin_valid_o               (spin_valid                ),
        .spin_ready_i               (spin_ready                ),
        .spin_o                     (cand_spin                 ),
        .energy_valid_i             (energy_valid              ),
        .energy_ready_o             (energy_ready              ),
        .result_i                   (em_result                 ),
        .flip_ren_o                 (flip_ren_o                ),
        .flip_raddr_o               (flip_raddr_o              ),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .flip_rdata_i               (flip_rdata_i              ),
        .energy_fifo_update_o       (energy_fifo_update_o      ),
        .energy_fifo_o              (energy_fifo_o             ),
        .spin_fifo_o                (spin_fifo_o               )
    );

endmodule

`default_nettype wire

/* tb_digital_macro.sv */
// ##############################
// digital macro testbench
// memory models, file driven runs
// and a random J energy check
// ##############################

`timescale 1ns/100ps
`default_nettype none

`include "ising_config.svh"

module tb_digital_macro;

    localparam int NS = `ISING_NUM_SPIN;
    localparam int PAR = `ISING_PARALLELISM;
    localparam int NB = `ISING_NUM_BLOCK;
    localparam int ROW_W = `ISING_NUM_SPIN * `ISING_BITJ;

    logic clk_i = 1'b0;
    logic reset_i;
    logic config_valid_fm_i;
    ising_data_pkg::spin_t config_spin_initial_i;
    logic en_comparison_i;
    logic cmpt_en_i;
    logic cmpt_idle_o;
    logic flip_ren_o;
    ising_data_pkg::faddr_t flip_raddr_o;
    ising_data_pkg::faddr_t icon_last_raddr_plus_one_i;
    ising_data_pkg::spin_t flip_rdata_i;
    logic dgt_weight_ren_o;
    ising_data_pkg::waddr_t dgt_weight_raddr_o;
    ising_data_pkg::weight_word_t dgt_weight_i;
    ising_data_pkg::hbias_t dgt_hbias_i;
    ising_data_pkg::hscaling_t dgt_hscaling_i;
    logic energy_fifo_update_o;
    ising_data_pkg::energy_t energy_fifo_o;
    ising_data_pkg::spin_t spin_fifo_o;

    // expected pulses per run with the random run at index 2
    logic [ROW_W-1:0] j_rows [NS];
    ising_data_pkg::hbias_t h_vec;
    ising_data_pkg::hscaling_t hscale;
    ising_data_pkg::spin_t start_spin;
    ising_data_pkg::spin_t icons [64];
    int icon_count;
    logic run_mode [3];
    int exp_count [3];
    ising_data_pkg::spin_t exp_spin [3][64];
    int exp_energy [3][64];

    int fd;
    integer seed;
    bit input_ok;
    int cur_run = 0;
    int pulse_idx = 0;
    int icon_idx = 0;
    int weight_blk = 0;
    int cycles = 0;
    int cycle_limit = 0;
    int mismatch_count = 0;
    int failure_count = 0;
    logic weight_req = 1'b0;
    logic flip_req = 1'b0;
    ising_data_pkg::waddr_t weight_addr;
    ising_data_pkg::faddr_t flip_addr;

    digital_macro digital_macro_i (
        .clk_i                      (clk_i                     ),
        .reset_i                    (reset_i                   ),
        .config_valid_fm_i          (config_valid_fm_i         ),
        .config_spin_initial_i      (config_spin_initial_i     ),
        .en_comparison_i            (en_comparison_i           ),
        .cmpt_en_i                  (cmpt_en_i                 ),
        .cmpt_idle_o                (cmpt_idle_o               ),
        .flip_ren_o                 (flip_ren_o                ),
        .flip_raddr_o               (flip_raddr_o              ),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .flip_rdata_i               (flip_rdata_i              ),
        .dgt_weight_ren_o           (dgt_weight_ren_o          ),
        .dgt_weight_raddr_o         (dgt_weight_raddr_o        ),
        .dgt_weight_i               (dgt_weight_i              ),
        .dgt_hbias_i                (dgt_hbias_i               ),
        .dgt_hscaling_i             (dgt_hscaling_i            ),
        .energy_fifo_update_o       (energy_fifo_update_o      ),
        .energy_fifo_o              (energy_fifo_o             ),
        .spin_fifo_o                (spin_fifo_o               )
    );

    always #2 clk_i = ~clk_i;

    function automatic ising_data_pkg::weight_word_t weight_word(input ising_data_pkg::waddr_t a);
        ising_data_pkg::weight_word_t w;
        for (int r = 0; r < PAR; r++) begin
            w[r*ROW_W +: ROW_W] = j_rows[int'(a) * PAR + r];
        end
        return w;
    endfunction

    function automatic int spin_sign(input logic b);
        return b ? 1 : -1;
    endfunction

    // sum of J[i][j]*si*sj over ordered pairs plus hscaling*h[i]*si
    function automatic int ising_energy(input ising_data_pkg::spin_t s);
        int e;
        logic signed [3:0] w;
        e = 0;
        for (int i = 0; i < NS; i++) begin
            for (int j = 0; j < NS; j++) begin
                w = j_rows[i][j*4 +: 4];
                e += int'(w) * spin_sign(s[i]) * spin_sign(s[j]);
            end
            w = h_vec[i*4 +: 4];
            e += int'(hscale) * int'(w) * spin_sign(s[i]);
        end
        return e;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, what, expected, actual);
        end
    endtask

    // skips comments that run from # to the end of the line
    task automatic next_token(output string tok);
        string rest;
        int n;
        tok = "";
        while (tok == "") begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                failure_count++;
                $display("tb_input.txt ended before all values were read");
                tok = "0";
            end else if (tok.getc(0) == "#") begin
                n = $fgets(rest, fd);
                tok = "";
            end
        end
    endtask

    task automatic read_hex(output logic [63:0] v);
        string tok;
        int n;
        next_token(tok);
        n = $sscanf(tok, "%h", v);
    endtask

    task automatic read_num(output int v);
        string tok;
        int n;
        next_token(tok);
        n = $sscanf(tok, "%d", v);
    endtask

    task automatic read_input(output bit ok);
        logic [63:0] v;
        int n;
        int cnt;
        ok = 1'b0;
        fd = $fopen("tb_input.txt", "r");
        if (fd != 0) begin
            for (int r = 0; r < NS; r++) begin
                read_hex(v);
                j_rows[r] = v;
            end
            read_hex(v);
            h_vec = v;
            read_num(n);
            hscale = ising_data_pkg::hscaling_t'(n);
            read_hex(v);
            start_spin = v[NS-1:0];
            read_num(icon_count);
            for (int i = 0; i < icon_count; i++) begin
                read_hex(v);
                icons[i] = v[NS-1:0];
            end
            for (int run = 0; run < 2; run++) begin
                read_num(n);
                run_mode[run] = n[0];
                read_num(cnt);
                exp_count[run] = cnt;
                for (int p = 0; p < cnt; p++) begin
                    read_hex(v);
                    exp_spin[run][p] = v[NS-1:0];
                    read_num(n);
                    exp_energy[run][p] = n;
                end
            end
            $fclose(fd);
            ok = (failure_count == 0);
        end
    endtask

    task automatic step();
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic apply_reset();
        reset_i = 1'b1;
        step();
        step();
        reset_i = 1'b0;
    endtask

    task automatic load_config(input ising_data_pkg::spin_t s, input logic mode);
        config_valid_fm_i = 1'b1;
        config_spin_initial_i = s;
        en_comparison_i = mode;
        step();
        config_valid_fm_i = 1'b0;
    endtask

    // runs one search until idle and checks the stored best result
    task automatic run_search(input int run, input int icons_used);
        int last;
        icon_last_raddr_plus_one_i = ising_data_pkg::faddr_t'(icons_used);
        cur_run = run;
        pulse_idx = 0;
        icon_idx = 0;
        cmpt_en_i = 1'b1;
        step();
        cmpt_en_i = 1'b0;
        @(negedge clk_i);
        while (!cmpt_idle_o) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        check_value("update pulse count", exp_count[run], pulse_idx);
        check_value("icon read count", icons_used, icon_idx);
        last = exp_count[run] - 1;
        check_value("final energy_fifo_o", exp_energy[run][last], energy_fifo_o);
        check_value("final spin_fifo_o", exp_spin[run][last], spin_fifo_o);
        step();
    endtask

    // memory requests are sampled before the edge and answered after it
    always @(negedge clk_i) begin
        weight_req = dgt_weight_ren_o;
        weight_addr = dgt_weight_raddr_o;
        flip_req = flip_ren_o;
        flip_addr = flip_raddr_o;
    end

    always @(posedge clk_i) begin
        #0.5;
        if (weight_req) begin
            dgt_weight_i = weight_word(weight_addr);
        end
        if (flip_req) begin
            flip_rdata_i = icons[flip_addr];
        end
    end

    always @(negedge clk_i) begin
        if (energy_fifo_update_o) begin
            if (pulse_idx < exp_count[cur_run]) begin
                check_value("energy_fifo_o", exp_energy[cur_run][pulse_idx], energy_fifo_o);
                check_value("spin_fifo_o", exp_spin[cur_run][pulse_idx], spin_fifo_o);
            end else begin
                check_value("energy_fifo_update_o", 0, 1);
            end
            pulse_idx++;
        end
        if (flip_ren_o) begin
            check_value("flip_raddr_o", icon_idx, flip_raddr_o);
            icon_idx++;
        end
        // weight reads walk the blocks in order and wrap
        if (reset_i) begin
            weight_blk = 0;
        end else if (dgt_weight_ren_o) begin
            check_value("dgt_weight_raddr_o", weight_blk, dgt_weight_raddr_o);
            weight_blk = (weight_blk + 1) % NB;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d mismatches, %0d other failures",
                     mismatch_count, failure_count + 1);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        reset_i = 1'b1;
        config_valid_fm_i = 1'b0;
        config_spin_initial_i = '0;
        en_comparison_i = 1'b0;
        cmpt_en_i = 1'b0;
        icon_last_raddr_plus_one_i = '0;
        flip_rdata_i = '0;
        dgt_weight_i = '0;
        dgt_hbias_i = '0;
        dgt_hscaling_i = '0;
        seed = 32'h83d6_47d3;
        read_input(input_ok);
        if (input_ok) begin
            cycle_limit = 50 * (2 * (icon_count + 1) + 1) + 200;
            dgt_hbias_i = h_vec;
            dgt_hscaling_i = hscale;
            apply_reset();
            @(negedge clk_i);
            check_value("cmpt_idle_o after reset", 1, cmpt_idle_o);
            check_value("flip_ren_o after reset", 0, flip_ren_o);
            check_value("energy_fifo_update_o after reset", 0, energy_fifo_update_o);
            step();
            for (int run = 0; run < 2; run++) begin
                load_config(start_spin, run_mode[run]);
                run_search(run, icon_count);
            end
            // reset drops the words still buffered from the old J
            reset_i = 1'b1;
            for (int r = 0; r < NS; r++) begin
                j_rows[r] = {$random(seed), $random(seed)};
            end
            apply_reset();
            exp_count[2] = 1;
            exp_spin[2][0] = ising_data_pkg::spin_t'($random(seed));
            exp_energy[2][0] = ising_energy(exp_spin[2][0]);
            load_config(exp_spin[2][0], 1'b0);
            run_search(2, 0);
        end else begin
            failure_count++;
            $display("could not read the stimulus file tb_input.txt");
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
ising_data_pkg.sv
ising_ctrl_pkg.sv
weight_fetch.sv
energy_monitor.sv
flip_manager.sv
digital_macro.sv
tb_digital_macro.sv

/* run.sh */
#!/bin/sh
# builds the digital macro testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_digital_macro -o tb_digital_macro_sim

./obj_dir/tb_digital_macro_sim | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb_input.txt */
# J rows 0..15, four per line; hex nibble j of row i is J[i][j], nibble 0 rightmost
# then h (nibble i is h[i]), hscaling, initial spin; icon count and icon patterns
# each run: comparison mode, update pulse count, then expected spin and energy per pulse
0000000000000030 0000000000000003 000000000000E000 0000000000000000
0000000000100000 0000000000000000 0000000000000000 0000000000000000
0005000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000F000003E1 2 0000
5 0001 0006 1100 8000 1000
# run a, comparison off
0 6
0000 8
0001 0
0007 20
1107 16
9107 16
8107 6
# run b, comparison on
1 4
0000 8
0001 0
1101 -4
0101 -14
